// ==== hw/loongarch_isa_pkg.sv ====
`default_nettype none

package loongarch_isa_pkg;

    // Register fields, each five bits wide.
    localparam int REG_FIELD_W = 5;
    localparam int RD_LSB      = 0;
    localparam int RJ_LSB      = 5;
    localparam int RK_LSB      = 10;

    // Three-register and shift forms, matched on bits 31..15.
    localparam logic [16:0] OP17_ADD_W   = 17'h00020;
    localparam logic [16:0] OP17_SUB_W   = 17'h00022;
    localparam logic [16:0] OP17_AND     = 17'h00029;
    localparam logic [16:0] OP17_OR      = 17'h0002a;
    localparam logic [16:0] OP17_XOR     = 17'h0002b;
    localparam logic [16:0] OP17_SLLI_W  = 17'h00081;
    localparam logic [16:0] OP17_SRLI_W  = 17'h00089;
    localparam logic [16:0] OP17_SYSCALL = 17'h00056;
    localparam logic [16:0] OP17_BREAK   = 17'h00054;

    // 12-bit immediate forms, matched on bits 31..22.
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_ANDI   = 10'h00d;
    localparam logic [9:0] OP10_ORI    = 10'h00e;
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;

    // Matched on bits 31..25.
    localparam logic [6:0] OP7_LU12I_W = 7'h0a;

    // Branches, matched on bits 31..26.
    localparam logic [5:0] OP6_BEQ = 6'h16;
    localparam logic [5:0] OP6_BNE = 6'h17;
    localparam logic [5:0] OP6_B   = 6'h14;

    // CSR access, matched on bits 31..24 with rj picking the operation.
    localparam logic [7:0] OP8_CSR  = 8'h04;
    localparam logic [4:0] RJ_CSRRD = 5'd0;
    localparam logic [4:0] RJ_CSRWR = 5'd1;

    typedef enum logic [4:0] {
        UOP_NOP,
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLL,
        UOP_SRL,
        UOP_LU12I,
        UOP_LD,
        UOP_ST,
        UOP_BEQ,
        UOP_BNE,
        UOP_B,
        UOP_SYSCALL,
        UOP_BREAK,
        UOP_CSRRD,
        UOP_CSRWR
    } uop_t;

endpackage

`default_nettype wire

// ==== hw/excp_pkg.sv ====
`default_nettype none

package excp_pkg;

    // LoongArch exception code, the Ecode field of ESTAT.
    typedef logic [6:0] ecode_t;

    localparam ecode_t ECODE_NONE = 7'h00;
    // Instruction fetch address error.
    localparam ecode_t ECODE_ADEF = 7'h08;
    // Instruction not defined.
    localparam ecode_t ECODE_INE  = 7'h0d;

endpackage

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input  logic [31:0]             inst,
    output loongarch_isa_pkg::uop_t uop,
    output logic [31:0]             imm,
    output logic [4:0]              rd,
    output logic [4:0]              rj,
    output logic [4:0]              rk,
    output logic                    is_alu,
    output logic                    is_syscall,
    output logic                    is_break,
    output logic                    is_privileged,
    output logic                    illegal
);
    import loongarch_isa_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic [7:0]  op8;

    logic [31:0] imm_si12;
    logic [31:0] imm_ui12;
    logic [31:0] imm_ui5;
    logic [31:0] imm_si20;
    logic [31:0] imm_offs16;
    logic [31:0] imm_offs26;
    logic [31:0] imm_csr;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];
    assign op8  = inst[31:24];

    assign rd = inst[RD_LSB +: REG_FIELD_W];
    assign rj = inst[RJ_LSB +: REG_FIELD_W];
    assign rk = inst[RK_LSB +: REG_FIELD_W];

    assign imm_si12   = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui12   = {20'b0, inst[21:10]};
    assign imm_ui5    = {27'b0, inst[14:10]};
    assign imm_si20   = {inst[24:5], 12'b0};
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    // The b offset is split, upper ten bits sit in 9..0.
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    assign imm_csr    = {18'b0, inst[23:10]};

    always_comb begin
        uop           = UOP_NOP;
        imm           = '0;
        is_alu        = 1'b0;
        is_syscall    = 1'b0;
        is_break      = 1'b0;
        is_privileged = 1'b0;
        illegal       = 1'b0;

        if (op17 == OP17_ADD_W) begin
            uop    = UOP_ADD;
            is_alu = 1'b1;
        end else if (op17 == OP17_SUB_W) begin
            uop    = UOP_SUB;
            is_alu = 1'b1;
        end else if (op17 == OP17_AND) begin
            uop    = UOP_AND;
            is_alu = 1'b1;
        end else if (op17 == OP17_OR) begin
            uop    = UOP_OR;
            is_alu = 1'b1;
        end else if (op17 == OP17_XOR) begin
            uop    = UOP_XOR;
            is_alu = 1'b1;
        end else if (op17 == OP17_SLLI_W) begin
            uop    = UOP_SLL;
            imm    = imm_ui5;
            is_alu = 1'b1;
        end else if (op17 == OP17_SRLI_W) begin
            uop    = UOP_SRL;
            imm    = imm_ui5;
            is_alu = 1'b1;
        end else if (op10 == OP10_ADDI_W) begin
            uop    = UOP_ADD;
            imm    = imm_si12;
            is_alu = 1'b1;
        end else if (op10 == OP10_ANDI) begin
            uop    = UOP_AND;
            imm    = imm_ui12;
            is_alu = 1'b1;
        end else if (op10 == OP10_ORI) begin
            uop    = UOP_OR;
            imm    = imm_ui12;
            is_alu = 1'b1;
        end else if (op7 == OP7_LU12I_W) begin
            uop    = UOP_LU12I;
            imm    = imm_si20;
            is_alu = 1'b1;
        end else if (op10 == OP10_LD_W) begin
            uop = UOP_LD;
            imm = imm_si12;
        end else if (op10 == OP10_ST_W) begin
            uop = UOP_ST;
            imm = imm_si12;
        end else if (op6 == OP6_BEQ) begin
            uop = UOP_BEQ;
            imm = imm_offs16;
        end else if (op6 == OP6_BNE) begin
            uop = UOP_BNE;
            imm = imm_offs16;
        end else if (op6 == OP6_B) begin
            uop = UOP_B;
            imm = imm_offs26;
        end else if (op17 == OP17_SYSCALL) begin
            uop        = UOP_SYSCALL;
            is_syscall = 1'b1;
        end else if (op17 == OP17_BREAK) begin
            uop      = UOP_BREAK;
            is_break = 1'b1;
        end else if (op8 == OP8_CSR && rj == RJ_CSRRD) begin
            uop           = UOP_CSRRD;
            imm           = imm_csr;
            is_privileged = 1'b1;
        end else if (op8 == OP8_CSR && rj == RJ_CSRWR) begin
            uop           = UOP_CSRWR;
            imm           = imm_csr;
            is_privileged = 1'b1;
        end else begin
            illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/id_reg.sv ====
`default_nettype none

module id_reg (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic                    id_valid,
    output logic                    id_ready,
    input  logic                    reg_ready,
    output logic                    reg_valid,
    input  logic [31:0]             fifo_id_inst0,
    input  logic [31:0]             fifo_id_inst1,
    input  logic [31:0]             fifo_id_pc0,
    input  logic [31:0]             fifo_id_pc1,
    input  logic [31:0]             fifo_id_badv,
    input  logic                    fifo_id_excp_flag,
    input  excp_pkg::ecode_t        fifo_id_exception,
    input  logic                    is_alu_0,
    input  logic                    is_alu_1,
    input  logic                    is_syscall_0,
    input  logic                    is_syscall_1,
    input  logic                    is_break_0,
    input  logic                    is_break_1,
    input  logic                    is_privileged_0,
    input  logic                    is_privileged_1,
    input  logic                    illegal_0,
    input  logic                    illegal_1,
    input  loongarch_isa_pkg::uop_t uop0,
    input  loongarch_isa_pkg::uop_t uop1,
    input  logic [31:0]             imm0,
    input  logic [31:0]             imm1,
    input  logic [4:0]              rd0,
    input  logic [4:0]              rd1,
    input  logic [4:0]              rj0,
    input  logic [4:0]              rj1,
    input  logic [4:0]              rk0,
    input  logic [4:0]              rk1,
    output logic [31:0]             id_reg_pc0,
    output logic [31:0]             id_reg_pc1,
    output logic [31:0]             id_reg_inst0,
    output logic [31:0]             id_reg_inst1,
    output logic [31:0]             id_reg_badv,
    output logic                    id_reg_excp_flag,
    output excp_pkg::ecode_t        id_reg_exception,
    output logic                    id_reg_excp_slot,
    output logic                    id_reg_is_alu_0,
    output logic                    id_reg_is_alu_1,
    output logic                    id_reg_is_syscall_0,
    output logic                    id_reg_is_syscall_1,
    output logic                    id_reg_is_break_0,
    output logic                    id_reg_is_break_1,
    output logic                    id_reg_is_privileged_0,
    output logic                    id_reg_is_privileged_1,
    output loongarch_isa_pkg::uop_t id_reg_uop0,
    output loongarch_isa_pkg::uop_t id_reg_uop1,
    output logic [31:0]             id_reg_imm0,
    output logic [31:0]             id_reg_imm1,
    output logic [4:0]              id_reg_rd0,
    output logic [4:0]              id_reg_rd1,
    output logic [4:0]              id_reg_rj0,
    output logic [4:0]              id_reg_rj1,
    output logic [4:0]              id_reg_rk0,
    output logic [4:0]              id_reg_rk1
);
    import loongarch_isa_pkg::*;
    import excp_pkg::*;

    logic   excp_flag_d;
    ecode_t excp_code_d;
    logic   excp_slot_d;
    logic   take;

    // Fetch faults come first, then the older slot.
    always_comb begin
        if (fifo_id_excp_flag) begin
            excp_flag_d = 1'b1;
            excp_code_d = fifo_id_exception;
            excp_slot_d = 1'b0;
        end else if (illegal_0) begin
            excp_flag_d = 1'b1;
            excp_code_d = ECODE_INE;
            excp_slot_d = 1'b0;
        end else if (illegal_1) begin
            excp_flag_d = 1'b1;
            excp_code_d = ECODE_INE;
            excp_slot_d = 1'b1;
        end else begin
            excp_flag_d = 1'b0;
            excp_code_d = ECODE_NONE;
            excp_slot_d = 1'b0;
        end
    end

    assign id_ready = reg_ready;

    // Load a real bundle, otherwise fill with a zero bubble.
    assign take = id_valid && !reset;

    always_ff @(posedge aclk) begin
        if (reset || reg_ready) begin
            reg_valid              <= take;
            id_reg_pc0             <= take ? fifo_id_pc0 : '0;
            id_reg_pc1             <= take ? fifo_id_pc1 : '0;
            id_reg_inst0           <= take ? fifo_id_inst0 : '0;
            id_reg_inst1           <= take ? fifo_id_inst1 : '0;
            id_reg_badv            <= take ? fifo_id_badv : '0;
            id_reg_excp_flag       <= take ? excp_flag_d : 1'b0;
            id_reg_exception       <= take ? excp_code_d : ECODE_NONE;
            id_reg_excp_slot       <= take ? excp_slot_d : 1'b0;
            id_reg_is_alu_0        <= take ? is_alu_0 : 1'b0;
            id_reg_is_alu_1        <= take ? is_alu_1 : 1'b0;
            id_reg_is_syscall_0    <= take ? is_syscall_0 : 1'b0;
            id_reg_is_syscall_1    <= take ? is_syscall_1 : 1'b0;
            id_reg_is_break_0      <= take ? is_break_0 : 1'b0;
            id_reg_is_break_1      <= take ? is_break_1 : 1'b0;
            id_reg_is_privileged_0 <= take ? is_privileged_0 : 1'b0;
            id_reg_is_privileged_1 <= take ? is_privileged_1 : 1'b0;
            id_reg_uop0            <= take ? uop0 : UOP_NOP;
            id_reg_uop1            <= take ? uop1 : UOP_NOP;
            id_reg_imm0            <= take ? imm0 : '0;
            id_reg_imm1            <= take ? imm1 : '0;
            id_reg_rd0             <= take ? rd0 : '0;
            id_reg_rd1             <= take ? rd1 : '0;
            id_reg_rj0             <= take ? rj0 : '0;
            id_reg_rj1             <= take ? rj1 : '0;
            id_reg_rk0             <= take ? rk0 : '0;
            id_reg_rk1             <= take ? rk1 : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic                    id_valid,
    output logic                    id_ready,
    input  logic                    reg_ready,
    output logic                    reg_valid,
    input  logic [31:0]             fifo_id_inst0,
    input  logic [31:0]             fifo_id_inst1,
    input  logic [31:0]             fifo_id_pc0,
    input  logic [31:0]             fifo_id_pc1,
    input  logic [31:0]             fifo_id_badv,
    input  logic                    fifo_id_excp_flag,
    input  excp_pkg::ecode_t        fifo_id_exception,
    output logic [31:0]             id_reg_pc0,
    output logic [31:0]             id_reg_pc1,
    output logic [31:0]             id_reg_inst0,
    output logic [31:0]             id_reg_inst1,
    output logic [31:0]             id_reg_badv,
    output logic                    id_reg_excp_flag,
    output excp_pkg::ecode_t        id_reg_exception,
    output logic                    id_reg_excp_slot,
    output logic                    id_reg_is_alu_0,
    output logic                    id_reg_is_alu_1,
    output logic                    id_reg_is_syscall_0,
    output logic                    id_reg_is_syscall_1,
    output logic                    id_reg_is_break_0,
    output logic                    id_reg_is_break_1,
    output logic                    id_reg_is_privileged_0,
    output logic                    id_reg_is_privileged_1,
    output loongarch_isa_pkg::uop_t id_reg_uop0,
    output loongarch_isa_pkg::uop_t id_reg_uop1,
    output logic [31:0]             id_reg_imm0,
    output logic [31:0]             id_reg_imm1,
    output logic [4:0]              id_reg_rd0,
    output logic [4:0]              id_reg_rd1,
    output logic [4:0]              id_reg_rj0,
    output logic [4:0]              id_reg_rj1,
    output logic [4:0]              id_reg_rk0,
    output logic [4:0]              id_reg_rk1
);
    import loongarch_isa_pkg::*;

    // Per-slot decode results, named to match the id_reg ports.
    uop_t        uop0;
    uop_t        uop1;
    logic [31:0] imm0;
    logic [31:0] imm1;
    logic [4:0]  rd0;
    logic [4:0]  rd1;
    logic [4:0]  rj0;
    logic [4:0]  rj1;
    logic [4:0]  rk0;
    logic [4:0]  rk1;
    logic        is_alu_0;
    logic        is_alu_1;
    logic        is_syscall_0;
    logic        is_syscall_1;
    logic        is_break_0;
    logic        is_break_1;
    logic        is_privileged_0;
    logic        is_privileged_1;
    logic        illegal_0;
    logic        illegal_1;

    inst_decoder u_dec0 (
        .inst          (fifo_id_inst0),
        .uop           (uop0),
        .imm           (imm0),
        .rd            (rd0),
        .rj            (rj0),
        .rk            (rk0),
        .is_alu        (is_alu_0),
        .is_syscall    (is_syscall_0),
        .is_break      (is_break_0),
        .is_privileged (is_privileged_0),
        .illegal       (illegal_0)
    );

    inst_decoder u_dec1 (
        .inst          (fifo_id_inst1),
        .uop           (uop1),
        .imm           (imm1),
        .rd            (rd1),
        .rj            (rj1),
        .rk            (rk1),
        .is_alu        (is_alu_1),
        .is_syscall    (is_syscall_1),
        .is_break      (is_break_1),
        .is_privileged (is_privileged_1),
        .illegal       (illegal_1)
    );

    id_reg u_id_reg (.*);

endmodule

`default_nettype wire

// ==== tests/decode_checker.sv ====
`default_nettype none

module decode_checker (
    input  logic         aclk,
    input  logic         reset,
    input  logic         id_valid,
    input  logic         id_ready,
    input  logic         reg_valid,
    input  logic         reg_ready,
    input  logic [280:0] exp_bundle,
    input  logic [280:0] dut_bundle,
    input  int           test_id,
    output int           error_count,
    output int           pending
);
    logic [280:0] exp_q[$];
    int           id_q[$];
    logic [280:0] held;
    logic [280:0] front;
    int           front_id;
    logic         was_stalled;
    logic         was_reset;

    function automatic string test_name(input int id);
        case (id)
            1:       return "directed";
            2:       return "random";
            3:       return "exceptions";
            4:       return "backpressure";
            5:       return "bubbles";
            default: return "reset";
        endcase
    endfunction

    initial begin
        error_count = 0;
        pending     = 0;
        was_stalled = 1'b0;
        was_reset   = 1'b1;
    end

    // Outputs are sampled at the edge, before the DUT registers update.
    always @(posedge aclk) begin
        if (!reset) begin
            if (id_ready !== reg_ready) begin
                $display("** Error %s: id_ready expected %b actual %b",
                         test_name(test_id), reg_ready, id_ready);
                error_count++;
            end
            if (was_reset && reg_valid !== 1'b0) begin
                $display("** Error %s: reg_valid after reset expected %b actual %b",
                         test_name(test_id), 1'b0, reg_valid);
                error_count++;
            end
            if (was_stalled && dut_bundle !== held) begin
                $display("** Error %s: held bundle expected %h actual %h",
                         test_name(test_id), held, dut_bundle);
                error_count++;
            end
            if (reg_valid !== 1'b1 && dut_bundle !== '0) begin
                $display("** Error %s: bubble expected %h actual %h",
                         test_name(test_id), 281'b0, dut_bundle);
                error_count++;
            end
            if (reg_valid && reg_ready) begin
                if (exp_q.size() == 0) begin
                    $display("DUT delivered a bundle that was never sent");
                    error_count++;
                end else begin
                    front    = exp_q.pop_front();
                    front_id = id_q.pop_front();
                    if (dut_bundle !== front) begin
                        $display("** Error %s: expected %h actual %h",
                                 test_name(front_id), front, dut_bundle);
                        error_count++;
                    end
                end
            end
            if (id_valid && id_ready) begin
                exp_q.push_back(exp_bundle);
                id_q.push_back(test_id);
            end
            was_stalled = reg_valid && !reg_ready;
            held        = dut_bundle;
        end
        was_reset = reset;
        pending   = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== tests/tb_decode_stage.sv ====
`default_nettype none

module tb_decode_stage;
    import loongarch_isa_pkg::*;
    import excp_pkg::*;

    localparam int N_RAND      = 200;
    localparam int N_BP        = 120;
    // Reset, directed, random, exceptions, back-pressure at four cycles each, bubbles, drains.
    localparam int STIM_CYCLES = 2 + 10 + N_RAND + 5 + 4 * N_BP + 8 + 6 * 4;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

    logic        aclk;
    logic        reset;
    logic        id_valid;
    logic        id_ready;
    logic        reg_ready;
    logic        reg_valid;
    logic [31:0] fifo_id_inst0;
    logic [31:0] fifo_id_inst1;
    logic [31:0] fifo_id_pc0;
    logic [31:0] fifo_id_pc1;
    logic [31:0] fifo_id_badv;
    logic        fifo_id_excp_flag;
    ecode_t      fifo_id_exception;
    logic [31:0] id_reg_pc0;
    logic [31:0] id_reg_pc1;
    logic [31:0] id_reg_inst0;
    logic [31:0] id_reg_inst1;
    logic [31:0] id_reg_badv;
    logic        id_reg_excp_flag;
    ecode_t      id_reg_exception;
    logic        id_reg_excp_slot;
    logic        id_reg_is_alu_0;
    logic        id_reg_is_alu_1;
    logic        id_reg_is_syscall_0;
    logic        id_reg_is_syscall_1;
    logic        id_reg_is_break_0;
    logic        id_reg_is_break_1;
    logic        id_reg_is_privileged_0;
    logic        id_reg_is_privileged_1;
    uop_t        id_reg_uop0;
    uop_t        id_reg_uop1;
    logic [31:0] id_reg_imm0;
    logic [31:0] id_reg_imm1;
    logic [4:0]  id_reg_rd0;
    logic [4:0]  id_reg_rd1;
    logic [4:0]  id_reg_rj0;
    logic [4:0]  id_reg_rj1;
    logic [4:0]  id_reg_rk0;
    logic [4:0]  id_reg_rk1;

    logic [280:0] exp_bundle;
    logic [280:0] dut_bundle;
    int           test_id;
    int           error_count;
    int           pending;
    int           cycles;
    int           errs_before;
    logic         bp_mode;
    logic [31:0]  rng_state;

    decode_stage decode_stage_i (.*);

    decode_checker checker_i (
        .aclk        (aclk),
        .reset       (reset),
        .id_valid    (id_valid),
        .id_ready    (id_ready),
        .reg_valid   (reg_valid),
        .reg_ready   (reg_ready),
        .exp_bundle  (exp_bundle),
        .dut_bundle  (dut_bundle),
        .test_id     (test_id),
        .error_count (error_count),
        .pending     (pending)
    );

    assign dut_bundle = {id_reg_pc0, id_reg_pc1, id_reg_inst0, id_reg_inst1, id_reg_badv,
        id_reg_excp_flag, id_reg_exception, id_reg_excp_slot,
        id_reg_is_alu_0, id_reg_is_syscall_0, id_reg_is_break_0, id_reg_is_privileged_0,
        id_reg_uop0, id_reg_imm0, id_reg_rd0, id_reg_rj0, id_reg_rk0,
        id_reg_is_alu_1, id_reg_is_syscall_1, id_reg_is_break_1, id_reg_is_privileged_1,
        id_reg_uop1, id_reg_imm1, id_reg_rd1, id_reg_rj1, id_reg_rk1};

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Layout is {illegal, alu, syscall, break, privileged, uop, imm, rd, rj, rk}.
    function automatic logic [56:0] ref_slot(input logic [31:0] w);
        uop_t        u;
        logic [31:0] im;
        logic        ill;
        logic [3:0]  f;
        u   = UOP_NOP;
        im  = '0;
        ill = 1'b0;
        if (w[31:15] == OP17_ADD_W) u = UOP_ADD;
        else if (w[31:15] == OP17_SUB_W) u = UOP_SUB;
        else if (w[31:15] == OP17_AND) u = UOP_AND;
        else if (w[31:15] == OP17_OR) u = UOP_OR;
        else if (w[31:15] == OP17_XOR) u = UOP_XOR;
        else if (w[31:15] == OP17_SLLI_W || w[31:15] == OP17_SRLI_W) begin
            u  = (w[31:15] == OP17_SLLI_W) ? UOP_SLL : UOP_SRL;
            im = {27'b0, w[14:10]};
        end else if (w[31:22] == OP10_ADDI_W || w[31:22] == OP10_LD_W
                     || w[31:22] == OP10_ST_W) begin
            u  = (w[31:22] == OP10_ADDI_W) ? UOP_ADD : (w[31:22] == OP10_LD_W) ? UOP_LD : UOP_ST;
            im = {{20{w[21]}}, w[21:10]};
        end else if (w[31:22] == OP10_ANDI || w[31:22] == OP10_ORI) begin
            u  = (w[31:22] == OP10_ANDI) ? UOP_AND : UOP_OR;
            im = {20'b0, w[21:10]};
        end else if (w[31:25] == OP7_LU12I_W) begin
            u  = UOP_LU12I;
            im = {w[24:5], 12'b0};
        end else if (w[31:26] == OP6_BEQ || w[31:26] == OP6_BNE) begin
            u  = (w[31:26] == OP6_BEQ) ? UOP_BEQ : UOP_BNE;
            im = {{14{w[25]}}, w[25:10], 2'b00};
        end else if (w[31:26] == OP6_B) begin
            u  = UOP_B;
            im = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        end else if (w[31:15] == OP17_SYSCALL) u = UOP_SYSCALL;
        else if (w[31:15] == OP17_BREAK) u = UOP_BREAK;
        else if (w[31:24] == OP8_CSR && (w[9:5] == RJ_CSRRD || w[9:5] == RJ_CSRWR)) begin
            u  = (w[9:5] == RJ_CSRRD) ? UOP_CSRRD : UOP_CSRWR;
            im = {18'b0, w[23:10]};
        end else ill = 1'b1;
        f = {u >= UOP_ADD && u <= UOP_LU12I, u == UOP_SYSCALL, u == UOP_BREAK,
             u == UOP_CSRRD || u == UOP_CSRWR};
        return {ill, f, u, im, w[4:0], w[9:5], w[14:10]};
    endfunction

    function automatic logic [280:0] ref_decode(input logic [31:0] i0, i1, pc0, pc1, badv,
                                                input logic xf, input ecode_t xc);
        logic [56:0] s0;
        logic [56:0] s1;
        logic        f;
        ecode_t      c;
        logic        sl;
        s0 = ref_slot(i0);
        s1 = ref_slot(i1);
        f  = xf || s0[56] || s1[56];
        c  = xf ? xc : (f ? ECODE_INE : ECODE_NONE);
        sl = !xf && !s0[56] && s1[56];
        return {pc0, pc1, i0, i1, badv, f, c, sl, s0[55:0], s1[55:0]};
    endfunction

    always_comb begin
        exp_bundle = ref_decode(fifo_id_inst0, fifo_id_inst1, fifo_id_pc0, fifo_id_pc1,
                                fifo_id_badv, fifo_id_excp_flag, fifo_id_exception);
    end

    // A listed opcode with random fields, or now and then a fully random word.
    function automatic logic [31:0] rand_inst();
        logic [31:0] r;
        logic [31:0] w;
        r = next_rand();
        w = next_rand();
        if (r[31:30] == 2'b00) return w;
        case (r[15:8] % 19)
            0:  return {OP17_ADD_W, w[14:0]};
            1:  return {OP17_SUB_W, w[14:0]};
            2:  return {OP17_AND, w[14:0]};
            3:  return {OP17_OR, w[14:0]};
            4:  return {OP17_XOR, w[14:0]};
            5:  return {OP17_SLLI_W, w[14:0]};
            6:  return {OP17_SRLI_W, w[14:0]};
            7:  return {OP17_SYSCALL, w[14:0]};
            8:  return {OP17_BREAK, w[14:0]};
            9:  return {OP10_ADDI_W, w[21:0]};
            10: return {OP10_ANDI, w[21:0]};
            11: return {OP10_ORI, w[21:0]};
            12: return {OP10_LD_W, w[21:0]};
            13: return {OP10_ST_W, w[21:0]};
            14: return {OP7_LU12I_W, w[24:0]};
            15: return {OP6_BEQ, w[25:0]};
            16: return {OP6_BNE, w[25:0]};
            17: return {OP6_B, w[25:0]};
            default: return {OP8_CSR, w[23:10], 4'b0, r[0], w[4:0]};
        endcase
    endfunction

    // Holds the bundle on the inputs until an edge accepts it.
    task automatic send(input logic [31:0] i0, i1, input logic xf, input ecode_t xc);
        logic [31:0] r;
        logic        accepted;
        r                 = next_rand();
        fifo_id_inst0     = i0;
        fifo_id_inst1     = i1;
        fifo_id_pc0       = {r[31:2], 2'b00};
        fifo_id_pc1       = {r[31:2], 2'b00} + 32'd4;
        fifo_id_badv      = r;
        fifo_id_excp_flag = xf;
        fifo_id_exception = xc;
        id_valid          = 1'b1;
        accepted          = 1'b0;
        while (!accepted) begin
            r         = next_rand();
            reg_ready = bp_mode ? r[20] : 1'b1;
            @(posedge aclk);
            accepted  = id_valid && id_ready;
            #1;
        end
        id_valid = 1'b0;
    endtask

    task automatic drain_and_report(input string name);
        id_valid  = 1'b0;
        reg_ready = 1'b1;
        while (pending != 0) begin
            @(posedge aclk);
            #1;
        end
        @(posedge aclk);
        #1;
        $display("%s: %0d errors", name, error_count - errs_before);
        errs_before = error_count;
    endtask

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rng_state         = 32'h59da_9a7f;
        reset             = 1'b1;
        id_valid          = 1'b0;
        reg_ready         = 1'b0;
        fifo_id_inst0     = '0;
        fifo_id_inst1     = '0;
        fifo_id_pc0       = '0;
        fifo_id_pc1       = '0;
        fifo_id_badv      = '0;
        fifo_id_excp_flag = 1'b0;
        fifo_id_exception = ECODE_NONE;
        bp_mode           = 1'b0;
        test_id           = 0;
        errs_before       = 0;
        repeat (2) @(posedge aclk);
        #1;
        reset = 1'b0;
        drain_and_report("reset");

        test_id = 1;
        send({OP17_ADD_W, 5'd3, 5'd2, 5'd1}, {OP17_SUB_W, 5'd31, 5'd30, 5'd29}, 1'b0, ECODE_NONE);
        send({OP17_AND, 5'd4, 5'd5, 5'd6}, {OP17_OR, 5'd7, 5'd8, 5'd9}, 1'b0, ECODE_NONE);
        send({OP17_XOR, 5'd1, 5'd1, 5'd1}, {OP17_SLLI_W, 5'd31, 5'd2, 5'd3}, 1'b0, ECODE_NONE);
        send({OP17_SRLI_W, 5'd17, 5'd4, 5'd5}, {OP10_ADDI_W, 12'hfff, 5'd6, 5'd7},
             1'b0, ECODE_NONE);
        send({OP10_ANDI, 12'h800, 5'd1, 5'd2}, {OP10_ORI, 12'hfff, 5'd3, 5'd4},
             1'b0, ECODE_NONE);
        send({OP7_LU12I_W, 20'h80001, 5'd10}, {OP10_LD_W, 12'h804, 5'd11, 5'd12},
             1'b0, ECODE_NONE);
        send({OP10_ST_W, 12'h7fc, 5'd13, 5'd14}, {OP6_BEQ, 16'hfffe, 5'd15, 5'd16},
             1'b0, ECODE_NONE);
        send({OP6_BNE, 16'h0040, 5'd17, 5'd18}, {OP6_B, 16'h1234, 10'h3ff}, 1'b0, ECODE_NONE);
        send({OP17_SYSCALL, 15'h0011}, {OP17_BREAK, 15'h7fff}, 1'b0, ECODE_NONE);
        send({OP8_CSR, 14'h0005, RJ_CSRRD, 5'd20}, {OP8_CSR, 14'h3fff, RJ_CSRWR, 5'd21},
             1'b0, ECODE_NONE);
        drain_and_report("directed");

        test_id = 2;
        repeat (N_RAND) send(rand_inst(), rand_inst(), 1'b0, ECODE_NONE);
        drain_and_report("random");

        // 32'hffffffff matches no opcode.
        test_id = 3;
        send(32'hffff_ffff, 32'hffff_ffff, 1'b1, ECODE_ADEF);
        send(32'hffff_ffff, 32'hffff_ffff, 1'b0, ECODE_NONE);
        send({OP17_ADD_W, 15'h0}, 32'hffff_ffff, 1'b0, ECODE_NONE);
        send(32'hffff_ffff, {OP17_ADD_W, 15'h0}, 1'b0, ECODE_NONE);
        send({OP17_OR, 15'h1}, {OP17_AND, 15'h2}, 1'b1, ECODE_ADEF);
        drain_and_report("exceptions");

        test_id = 4;
        bp_mode = 1'b1;
        repeat (N_BP) send(rand_inst(), rand_inst(), next_rand() < 32'h2000_0000, ECODE_ADEF);
        bp_mode = 1'b0;
        drain_and_report("backpressure");

        test_id       = 5;
        fifo_id_inst0 = next_rand();
        fifo_id_inst1 = next_rand();
        repeat (8) begin
            @(posedge aclk);
            #1;
        end
        drain_and_report("bubbles");

        $display("checks done: %0d errors, %0d bundles never delivered", error_count, pending);
        if (error_count == 0 && pending == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/loongarch_isa_pkg.sv
hw/excp_pkg.sv
hw/inst_decoder.sv
hw/id_reg.sv
hw/decode_stage.sv
tests/decode_checker.sv
tests/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - hw/loongarch_isa_pkg.sv
  - hw/excp_pkg.sv
  - hw/inst_decoder.sv
  - hw/id_reg.sv
  - hw/decode_stage.sv
  - target: test
    files:
      - tests/decode_checker.sv
      - tests/tb_decode_stage.sv
